// File: compile.f
hw/csrPkg.sv
hw/csrAccessIf.sv
hw/csrAccessStage.sv
hw/trapStage.sv
hw/machineCsrFile.sv
hw/csrUnit.sv
verification/clockGen.sv
verification/csrUnitTb.sv

// File: hw/csrAccessIf.sv
/*
 * CSR access channel
 * Decoded address and write data out, read data and legality back
 */

`timescale 1ns/10ps

interface csrAccessIf import csrPkg::*; #(
  parameter int XLEN = 32
) ();

  csrAdrT          adr;                    // CSR address from InstrM[31:20]
  logic [XLEN-1:0] writeVal;               // Result of read-modify-write
  logic            writeEn;                // Write at next rising clk
  logic [XLEN-1:0] readVal;                // Current register value
  logic            adrValid;               // Address exists
  logic            readOnly;               // Address may not be written

  // Access stage side
  modport stage (
    output adr,
    output writeVal,
    output writeEn,
    input  readVal,
    input  adrValid,
    input  readOnly
  );

  // Register file side
  modport file (
    input  adr,
    input  writeVal,
    input  writeEn,
    output readVal,
    output adrValid,
    output readOnly
  );

endinterface

// File: hw/csrAccessStage.sv
/*
 * CSR access stage
 * Decodes CSRRW/CSRRS/CSRRC, forms the write value, checks legality
 * and registers the read value for writeback
 */

`timescale 1ns/10ps

module csrAccessStage import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic [31:0]     InstrM,          // CSR instruction in memory stage
  input  logic [XLEN-1:0] SrcAM,           // rs1 value
  input  logic            CSRReadM,
  input  logic            CSRWriteM,
  input  logic            InstrValidM,
  input  logic            StallW,
  input  logic            FlushW,
  input  privModeT        PrivilegeModeW,
  csrAccessIf.stage       acc,
  output logic            IllegalCSRAccessM,
  output logic [XLEN-1:0] CSRReadValW
);

  csrOpT           op;
  logic [XLEN-1:0] srcVal;
  logic            insufficientPriv;
  logic            writeReadOnly;
  logic            writePermitted;
  logic            instrLive;

  ////////////////////////////////
  // Decode and read-modify-write
  ////////////////////////////////

  assign acc.adr = InstrM[31:20];
  assign op      = csrOpT'(InstrM[13:12]);   // funct3[1:0]

  // funct3[2] picks the 5-bit immediate in the rs1 field
  assign srcVal = InstrM[14] ? XLEN'(InstrM[19:15]) : SrcAM;

  always_comb begin
    case (op)
      RW:      acc.writeVal = srcVal;
      RS:      acc.writeVal = acc.readVal | srcVal;
      RC:      acc.writeVal = acc.readVal & ~srcVal;
      default: acc.writeVal = acc.readVal;   // Not a CSR op, no change
    endcase
  end

  ////////////////////////////////
  // Legality
  ////////////////////////////////

  // Bits 9:8 give the lowest privilege allowed
  assign insufficientPriv = (acc.adr[9:8] == 2'b11) && (PrivilegeModeW != M);

  assign writeReadOnly = CSRWriteM & acc.readOnly;

  // Unknown or privileged only counts on a read, read-only on a write
  assign IllegalCSRAccessM = ((~acc.adrValid | insufficientPriv) & CSRReadM) | writeReadOnly;

  assign writePermitted = acc.adrValid & ~insufficientPriv & ~acc.readOnly;

  // Only a valid instruction that is neither stalled nor flushed commits
  assign instrLive   = InstrValidM & ~StallW & ~FlushW;
  assign acc.writeEn = CSRWriteM & writePermitted & instrLive;

  ////////////////////////////////
  // Writeback read register
  ////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      CSRReadValW <= '0;
    end else if (!StallW) begin             // Holds while stalled
      CSRReadValW <= FlushW ? '0 : acc.readVal;   // Old value, before the write
    end
  end

endmodule

// File: hw/csrPkg.sv
/*
 * Machine-mode CSR unit definitions
 * Addresses, cause codes, privilege and CSR operation types
 */

package csrPkg;

  ////////////////////////////////
  // Privilege and CSR operations
  ////////////////////////////////

  typedef enum logic [1:0] {
    U = 2'b00,                             // User mode
    M = 2'b11                              // Machine mode
  } privModeT;

  typedef enum logic [1:0] {
    NONE = 2'b00,
    RW   = 2'b01,                          // Swap
    RS   = 2'b10,                          // Set bits
    RC   = 2'b11                           // Clear bits
  } csrOpT;

  typedef logic [11:0] csrAdrT;
  typedef logic [3:0]  causeT;

  // Machine CSR addresses
  localparam csrAdrT MSTATUS  = 12'h300;
  localparam csrAdrT MISA     = 12'h301;
  localparam csrAdrT MIE      = 12'h304;
  localparam csrAdrT MTVEC    = 12'h305;
  localparam csrAdrT MSCRATCH = 12'h340;
  localparam csrAdrT MEPC     = 12'h341;
  localparam csrAdrT MCAUSE   = 12'h342;
  localparam csrAdrT MTVAL    = 12'h343;
  localparam csrAdrT MIP      = 12'h344;
  localparam csrAdrT MHARTID  = 12'hF14;   // Read-only range

  ////////////////////////////////
  // Exception cause codes
  ////////////////////////////////

  localparam causeT INSTR_MISALIGNED   = 4'd0;
  localparam causeT INSTR_ACCESS_FAULT = 4'd1;
  localparam causeT ILLEGAL_INSTR      = 4'd2;
  localparam causeT BREAKPOINT         = 4'd3;
  localparam causeT LOAD_MISALIGNED    = 4'd4;
  localparam causeT LOAD_ACCESS_FAULT  = 4'd5;
  localparam causeT STORE_MISALIGNED   = 4'd6;
  localparam causeT STORE_ACCESS_FAULT = 4'd7;
  localparam causeT INSTR_PAGE_FAULT   = 4'd12;
  localparam causeT LOAD_PAGE_FAULT    = 4'd13;
  localparam causeT STORE_PAGE_FAULT   = 4'd15;

  // Interrupt bit positions in mip and mie
  localparam int MSI = 3;
  localparam int MTI = 7;
  localparam int MEI = 11;

  // mstatus field positions
  localparam int MSTATUS_MIE_POS  = 3;
  localparam int MSTATUS_MPIE_POS = 7;
  localparam int MSTATUS_MPP_POS  = 11;    // Two bits, 12:11

  // misa extension field: I, M and U
  localparam logic [25:0] MISA_EXT = 26'h0101100;

endpackage

// File: hw/csrUnit.sv
/*
 * Machine-mode CSR unit
 * Access stage feeding the CSR file and trap stage
 */

`timescale 1ns/10ps

module csrUnit import csrPkg::*; #(
  parameter int XLEN     = 32,
  parameter bit VECTORED = 1'b1
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            StallW,
  input  logic            FlushW,
  input  logic            InstrValidM,
  input  logic            CSRReadM,
  input  logic            CSRWriteM,
  input  logic            TrapM,
  input  logic            mretM,
  input  logic            InterruptM,
  input  logic            MTimerInt,       // Timer interrupt
  input  logic            MExtInt,         // External interrupt
  input  logic            MSwInt,          // Software interrupt
  input  logic [31:0]     InstrM,
  input  logic [XLEN-1:0] PCM,
  input  logic [XLEN-1:0] SrcAM,
  input  logic [XLEN-1:0] IEUAdrxTvalM,
  input  causeT           CauseM,
  input  privModeT        PrivilegeModeW,
  output logic [XLEN-1:0] CSRReadValW,
  output logic [XLEN-1:0] TrapVectorM,     // PC on trap entry
  output logic [XLEN-1:0] EPCM,            // PC on mret
  output logic            IllegalCSRAccessM,
  output logic            STATUS_MIE,
  output privModeT        STATUS_MPP,
  output logic [11:0]     MIP_REGW,
  output logic [11:0]     MIE_REGW
);

  logic [XLEN-1:0] mtvec, mepc;
  logic [XLEN-1:0] nextEpc, nextCause, nextTval;

  csrAccessIf #(.XLEN(XLEN)) accIf ();

  ////////////////////////////////
  // Stages
  ////////////////////////////////

  csrAccessStage #(.XLEN(XLEN)) accessStage_i (
    .clk, .arstN, .InstrM, .SrcAM, .CSRReadM, .CSRWriteM,
    .InstrValidM, .StallW, .FlushW, .PrivilegeModeW,
    .acc(accIf.stage),
    .IllegalCSRAccessM, .CSRReadValW
  );

  machineCsrFile #(.XLEN(XLEN)) csrFile_i (
    .clk, .arstN, .StallW, .TrapM, .mretM, .PrivilegeModeW,
    .MTimerInt, .MExtInt, .MSwInt,
    .nextEpc, .nextCause, .nextTval,
    .acc(accIf.file),
    .mtvec, .mepc, .STATUS_MIE, .STATUS_MPP, .MIP_REGW, .MIE_REGW
  );

  trapStage #(.XLEN(XLEN), .VECTORED(VECTORED)) trapStage_i (
    .TrapM, .InterruptM, .mretM, .CauseM, .PCM, .InstrM, .IEUAdrxTvalM,
    .mtvec, .mepc,
    .TrapVectorM, .EPCM, .nextEpc, .nextCause, .nextTval
  );

endmodule

// File: hw/machineCsrFile.sv
/*
 * Machine CSR file
 * mstatus, misa, mhartid, mtvec, mscratch, mepc, mcause, mtval, mie, mip
 * with read decode and trap/mret updates
 */

`timescale 1ns/10ps

module machineCsrFile import csrPkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arstN,
  input  logic            StallW,
  input  logic            TrapM,
  input  logic            mretM,
  input  privModeT        PrivilegeModeW,
  input  logic            MTimerInt,
  input  logic            MExtInt,
  input  logic            MSwInt,
  input  logic [XLEN-1:0] nextEpc,
  input  logic [XLEN-1:0] nextCause,
  input  logic [XLEN-1:0] nextTval,
  csrAccessIf.file        acc,
  output logic [XLEN-1:0] mtvec,
  output logic [XLEN-1:0] mepc,
  output logic            STATUS_MIE,
  output privModeT        STATUS_MPP,
  output logic [11:0]     MIP_REGW,
  output logic [11:0]     MIE_REGW
);

  localparam logic [1:0]  MXL      = (XLEN == 64) ? 2'd2 : 2'd1;
  localparam logic [11:0] IRQ_MASK = (12'd1 << MSI) | (12'd1 << MTI) | (12'd1 << MEI);

  logic            statusMpie;
  logic [XLEN-1:0] mscratch, mcause, mtval;
  logic [XLEN-1:0] mstatusVal, misaVal;
  logic            trapEn, retEn, csrWr;

  // Trap beats mret beats a CSR write, nothing moves while stalled
  assign trapEn = TrapM & ~StallW;
  assign retEn  = mretM & ~TrapM & ~StallW;
  assign csrWr  = acc.writeEn & ~trapEn & ~retEn;

  // Hardwired interrupt pending bits
  always_comb begin
    MIP_REGW      = '0;
    MIP_REGW[MSI] = MSwInt;
    MIP_REGW[MTI] = MTimerInt;
    MIP_REGW[MEI] = MExtInt;
  end

  ////////////////////////////////
  // mstatus
  ////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      STATUS_MIE <= 1'b0;
      statusMpie <= 1'b0;
      STATUS_MPP <= U;
    end else if (trapEn) begin
      statusMpie <= STATUS_MIE;
      STATUS_MIE <= 1'b0;               // Interrupts off in handler
      STATUS_MPP <= PrivilegeModeW;
    end else if (retEn) begin
      STATUS_MIE <= statusMpie;
      statusMpie <= 1'b1;
      STATUS_MPP <= U;                  // Lowest supported mode
    end else if (csrWr && acc.adr == MSTATUS) begin
      STATUS_MIE <= acc.writeVal[MSTATUS_MIE_POS];
      statusMpie <= acc.writeVal[MSTATUS_MPIE_POS];
      // Only U and M exist, anything but 3 lands on U
      STATUS_MPP <= (acc.writeVal[MSTATUS_MPP_POS +: 2] == 2'b11) ? M : U;
    end
  end

  ////////////////////////////////
  // Trap registers and the rest
  ////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      MIE_REGW <= '0;
    end else if (trapEn) begin
      mepc   <= nextEpc;                // Already word aligned
      mcause <= nextCause;
      mtval  <= nextTval;
    end else if (csrWr) begin
      case (acc.adr)
        MEPC:     mepc     <= {acc.writeVal[XLEN-1:2], 2'b00};
        MCAUSE:   mcause   <= {acc.writeVal[XLEN-1], {(XLEN-5){1'b0}}, acc.writeVal[3:0]};
        MTVAL:    mtval    <= acc.writeVal;
        MTVEC:    mtvec    <= {acc.writeVal[XLEN-1:2], 1'b0, acc.writeVal[0]};  // Mode 0 or 1
        MSCRATCH: mscratch <= acc.writeVal;
        MIE:      MIE_REGW <= acc.writeVal[11:0] & IRQ_MASK;
        default:  ;                     // mip, misa, mhartid ignore writes
      endcase
    end
  end

  ////////////////////////////////
  // Read decode
  ////////////////////////////////

  always_comb begin
    mstatusVal                            = '0;
    mstatusVal[MSTATUS_MIE_POS]           = STATUS_MIE;
    mstatusVal[MSTATUS_MPIE_POS]          = statusMpie;
    mstatusVal[MSTATUS_MPP_POS +: 2]      = STATUS_MPP;
  end

  assign misaVal = {MXL, {(XLEN-28){1'b0}}, MISA_EXT};

  always_comb begin
    acc.adrValid = 1'b1;
    acc.readVal  = '0;
    case (acc.adr)
      MSTATUS:  acc.readVal = mstatusVal;
      MISA:     acc.readVal = misaVal;
      MIE:      acc.readVal = XLEN'(MIE_REGW);
      MTVEC:    acc.readVal = mtvec;
      MSCRATCH: acc.readVal = mscratch;
      MEPC:     acc.readVal = mepc;
      MCAUSE:   acc.readVal = mcause;
      MTVAL:    acc.readVal = mtval;
      MIP:      acc.readVal = XLEN'(MIP_REGW);
      MHARTID:  acc.readVal = '0;        // Single hart
      default:  acc.adrValid = 1'b0;
    endcase
  end

  // Top address range plus misa
  assign acc.readOnly = (acc.adr[11:10] == 2'b11) || (acc.adr == MISA);

endmodule

// File: hw/trapStage.sv
/*
 * Trap stage
 * Trap vector, return PC and the mepc/mcause/mtval values for trap entry
 */

`timescale 1ns/10ps

module trapStage import csrPkg::*; #(
  parameter int XLEN     = 32,
  parameter bit VECTORED = 1'b1
) (
  input  logic            TrapM,
  input  logic            InterruptM,
  input  logic            mretM,
  input  causeT           CauseM,
  input  logic [XLEN-1:0] PCM,
  input  logic [31:0]     InstrM,
  input  logic [XLEN-1:0] IEUAdrxTvalM,    // Faulting load/store address
  input  logic [XLEN-1:0] mtvec,
  input  logic [XLEN-1:0] mepc,
  output logic [XLEN-1:0] TrapVectorM,
  output logic [XLEN-1:0] EPCM,
  output logic [XLEN-1:0] nextEpc,
  output logic [XLEN-1:0] nextCause,
  output logic [XLEN-1:0] nextTval
);

  logic [XLEN-1:0] faultTval;
  logic [XLEN-1:0] tvecBase;

  ////////////////////////////////
  // mtval selection
  ////////////////////////////////

  always_comb begin
    if (InterruptM) begin
      faultTval = '0;
    end else begin
      case (CauseM)
        INSTR_MISALIGNED, INSTR_ACCESS_FAULT,
        BREAKPOINT, INSTR_PAGE_FAULT:
          faultTval = PCM;
        ILLEGAL_INSTR:
          faultTval = XLEN'(InstrM);            // Offending instruction word
        LOAD_MISALIGNED, LOAD_ACCESS_FAULT, STORE_MISALIGNED,
        STORE_ACCESS_FAULT, LOAD_PAGE_FAULT, STORE_PAGE_FAULT:
          faultTval = IEUAdrxTvalM;
        default:
          faultTval = '0;                       // ecall and the rest
      endcase
    end
  end

  // Trap bus stays quiet between traps
  assign nextEpc   = TrapM ? {PCM[XLEN-1:2], 2'b00} : '0;
  assign nextCause = TrapM ? {InterruptM, {(XLEN-5){1'b0}}, CauseM} : '0;
  assign nextTval  = TrapM ? faultTval : '0;

  ////////////////////////////////
  // Trap vector
  ////////////////////////////////

  assign tvecBase = {mtvec[XLEN-1:2], 2'b00};

  generate
    if (VECTORED) begin : gVectored
      logic vectoredM;

      // Mode 1 and an interrupt, base is 64-byte aligned so cause is concatenated
      assign vectoredM   = InterruptM & (mtvec[1:0] == 2'b01);
      assign TrapVectorM = vectoredM ? {tvecBase[XLEN-1:6], CauseM, 2'b00} : tvecBase;
    end else begin : gDirect
      assign TrapVectorM = tvecBase;
    end
  endgenerate

  // Return target, a trap in the same cycle wins
  assign EPCM = (mretM & ~TrapM) ? mepc : '0;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the CSR unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module csrUnitTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/VcsrUnitTb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// File: verification/clockGen.sv
/*
 * Testbench clock and reset
 * Free-running clock, active-low reset held for a few cycles
 */

`timescale 1ns/10ps

module clockGen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;                          // Release away from the rising edge
  end

endmodule

// File: verification/csrUnitTb.sv
/*
 * CSR unit testbench
 * LFSR stimulus against a small CSR model, immediate assertions check
 */

`timescale 1ns/10ps

module csrUnitTb import csrPkg::*;;

  logic clk, arstN;
  logic StallW, FlushW, InstrValidM, CSRReadM, CSRWriteM, TrapM, mretM, InterruptM;
  logic MTimerInt, MExtInt, MSwInt;
  logic [31:0] InstrM, PCM, SrcAM, IEUAdrxTvalM, CSRReadValW, TrapVectorM, EPCM;
  causeT CauseM;
  privModeT PrivilegeModeW, STATUS_MPP;
  logic IllegalCSRAccessM, STATUS_MIE;
  logic [11:0] MIP_REGW, MIE_REGW;

  logic [31:0] lfsr = 32'h7c3;
  logic [31:0] readVal, combVec, combEpc;   // Results of the last access
  logic combIllegal;
  logic [31:0] scratchM, mtvecM, mepcM;     // Reference model
  logic mieM, mpieM;

  clockGen clkGen_i (.clk, .arstN);

  csrUnit #(.XLEN(32), .VECTORED(1'b1)) csrUnit_i (.*);

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] csrInstr(input csrAdrT adr, input logic [2:0] f3,
                                           input logic [4:0] rs1);
    return {adr, rs1, f3, 5'd1, 7'h73};     // SYSTEM opcode, rd x1
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic setIdle();
    InstrM      = csrInstr(MSCRATCH, 3'b010, 5'd0);   // Quiet mscratch read
    SrcAM       = '0;
    {CSRReadM, CSRWriteM, StallW, FlushW, InstrValidM} = '0;
    {TrapM, mretM, InterruptM} = '0;
    CauseM         = '0;
    PCM            = '0;
    IEUAdrxTvalM   = '0;
    PrivilegeModeW = M;
  endtask

  // Starts and ends on a falling edge
  task automatic doAccess(input csrAdrT adr, input logic [2:0] f3, input logic [31:0] src,
                          input logic rd, input logic wr, input logic stall,
                          input logic flush);
    InstrM      = csrInstr(adr, f3, src[4:0]);
    SrcAM       = src;
    CSRReadM    = rd;
    CSRWriteM   = wr;
    StallW      = stall;
    FlushW      = flush;
    InstrValidM = 1'b1;
    #10;
    combIllegal = IllegalCSRAccessM;
    combVec     = TrapVectorM;
    combEpc     = EPCM;
    @(posedge clk);
    @(negedge clk);
    readVal = CSRReadValW;                  // Registered, stable mid-cycle
    setIdle();
  endtask

  task automatic readCsr(input csrAdrT adr);
    doAccess(adr, 3'b010, 32'd0, 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  // One read-modify-write on mscratch, model applied afterwards
  task automatic rmwScratch(input logic [2:0] f3);
    logic [31:0] src, srcUsed;
    src     = randBits(32);
    srcUsed = f3[2] ? {27'd0, src[4:0]} : src;
    doAccess(MSCRATCH, f3, src, 1'b1, 1'b1, 1'b0, 1'b0);
    check("rmw old value", scratchM, readVal);
    case (f3[1:0])
      2'b01:   scratchM = srcUsed;
      2'b10:   scratchM = scratchM | srcUsed;
      default: scratchM = scratchM & ~srcUsed;
    endcase
  endtask

  task automatic trapCheck(input logic intr, input causeT cause, input privModeT mode);
    logic [31:0] pc, adr, expVec, expTval, instr;
    pc    = randBits(32);
    adr   = randBits(32);
    instr = csrInstr(MSTATUS, 3'b010, 5'd0);
    TrapM = 1'b1;
    InterruptM     = intr;
    CauseM         = cause;
    PCM            = pc;
    IEUAdrxTvalM   = adr;
    PrivilegeModeW = mode;                  // Mode the trap is taken from
    doAccess(MSTATUS, 3'b010, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
    expVec = mtvecM & ~32'h3;
    if (intr && mtvecM[0]) expVec = expVec + {26'd0, cause, 2'b00};   // Vectored
    check("trap vector", expVec, combVec);
    if (intr) expTval = '0;
    else if (cause inside {4'd0, 4'd1, 4'd3, 4'd12}) expTval = pc;
    else if (cause == 4'd2) expTval = instr;
    else if (cause inside {4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15}) expTval = adr;
    else expTval = '0;
    mpieM = mieM;
    mieM  = 1'b0;
    mepcM = pc & ~32'h3;
    check("trap MIE", {31'd0, mieM}, {31'd0, STATUS_MIE});
    check("trap MPP", {30'd0, mode}, {30'd0, STATUS_MPP});
    readCsr(MSTATUS);
    check("trap MPIE", {31'd0, mpieM}, {31'd0, readVal[7]});
    readCsr(MEPC);
    check("trap mepc", mepcM, readVal);
    readCsr(MCAUSE);
    check("trap mcause", {intr, 27'd0, cause}, readVal);
    readCsr(MTVAL);
    check("trap mtval", expTval, readVal);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] held, irq, expMip, mieVal;
    causeT pcCauses[4];
    causeT adrCauses[6];
    causeT irqCauses[3];
    int waitCnt;
    pcCauses  = '{4'd0, 4'd1, 4'd3, 4'd12};
    adrCauses = '{4'd4, 4'd5, 4'd6, 4'd7, 4'd13, 4'd15};
    irqCauses = '{4'd3, 4'd7, 4'd11};
    setIdle();
    {MTimerInt, MExtInt, MSwInt} = '0;
    {scratchM, mtvecM, mepcM} = '0;
    {mieM, mpieM} = '0;
    waitCnt = 0;
    while (arstN !== 1'b1) begin            // Wait for reset release
      @(negedge clk);
      waitCnt++;
      if (waitCnt > 20) begin
        $display("ERRORS FOUND");
        $fatal(1, "reset was never released");
      end
    end
    @(negedge clk);

    // Reset values
    readCsr(MSCRATCH); check("reset mscratch", 32'd0, readVal);
    readCsr(MEPC);     check("reset mepc", 32'd0, readVal);
    readCsr(MCAUSE);   check("reset mcause", 32'd0, readVal);
    readCsr(MHARTID);  check("reset mhartid", 32'd0, readVal);
    readCsr(MISA);     check("reset misa", {2'b01, 4'd0, MISA_EXT}, readVal);
    check("reset MIE", 32'd0, {31'd0, STATUS_MIE});
    check("reset MPP", {30'd0, U}, {30'd0, STATUS_MPP});

    // Read-modify-write, register and immediate sources
    for (int n = 0; n < 8; n++) begin
      rmwScratch(3'b001);
      rmwScratch(3'b010);
      rmwScratch(3'b011);
      rmwScratch(3'b101);
      rmwScratch(3'b110);
      rmwScratch(3'b111);
    end
    held = CSRReadValW;
    doAccess(MSCRATCH, 3'b001, randBits(32), 1'b1, 1'b1, 1'b1, 1'b0);
    check("stall holds read", held, readVal);
    doAccess(MSCRATCH, 3'b001, randBits(32), 1'b1, 1'b1, 1'b0, 1'b1);
    check("flush clears read", 32'd0, readVal);
    readCsr(MSCRATCH); check("no write on stall/flush", scratchM, readVal);

    // Illegal accesses
    readCsr(12'h7C0);  check("unknown address", 32'd1, {31'd0, combIllegal});
    PrivilegeModeW = U;
    doAccess(MSCRATCH, 3'b010, 32'd0, 1'b1, 1'b0, 1'b0, 1'b0);
    check("U-mode mscratch", 32'd1, {31'd0, combIllegal});
    doAccess(MHARTID, 3'b001, 32'd5, 1'b1, 1'b1, 1'b0, 1'b0);
    check("write mhartid", 32'd1, {31'd0, combIllegal});
    readCsr(MSCRATCH); check("legal access", 32'd0, {31'd0, combIllegal});

    // Trap entry, vectored mtvec, MIE set first
    mtvecM = (randBits(32) & ~32'h3f) | 32'h1;
    doAccess(MTVEC, 3'b001, mtvecM, 1'b1, 1'b1, 1'b0, 1'b0);
    doAccess(MSTATUS, 3'b110, 32'd8, 1'b1, 1'b1, 1'b0, 1'b0);
    mieM = 1'b1;
    trapCheck(1'b0, pcCauses[randBits(2)], M);
    trapCheck(1'b0, 4'd2, U);
    trapCheck(1'b0, adrCauses[randBits(3) % 6], M);
    trapCheck(1'b1, irqCauses[randBits(2) % 3], M);

    // mret, MPIE set again so MIE has to change
    doAccess(MSTATUS, 3'b010, 32'h80, 1'b1, 1'b1, 1'b0, 1'b0);
    mpieM = 1'b1;
    mretM = 1'b1;
    doAccess(MSTATUS, 3'b010, 32'd0, 1'b0, 1'b0, 1'b0, 1'b0);
    mieM = mpieM;
    check("mret EPCM", mepcM, combEpc);
    check("mret MIE", {31'd0, mieM}, {31'd0, STATUS_MIE});
    check("mret MPP", {30'd0, U}, {30'd0, STATUS_MPP});

    // Interrupt pending bits, each bit seen high and low
    irq = randBits(3);
    for (int k = 0; k < 2; k++) begin
      {MSwInt, MTimerInt, MExtInt} = irq[2:0];
      expMip = {20'd0, irq[0], 3'd0, irq[1], 3'd0, irq[2], 3'd0};
      readCsr(MIP);
      check("mip bits", expMip, {20'd0, MIP_REGW});
      check("mip read", expMip, readVal);
      doAccess(MIP, 3'b010, 32'hffff_ffff, 1'b1, 1'b1, 1'b0, 1'b0);
      readCsr(MIP);
      check("mip after set", expMip, readVal);
      irq = ~irq;
    end

    // Interrupt enables, only MSI, MTI and MEI exist
    mieVal = randBits(32);
    for (int k = 0; k < 2; k++) begin
      doAccess(MIE, 3'b001, mieVal, 1'b1, 1'b1, 1'b0, 1'b0);
      check("mie bits", {20'd0, mieVal[11:0] & 12'h888}, {20'd0, MIE_REGW});
      mieVal = ~mieVal;
    end

    $display("NO ERRORS");
    $finish;
  end

  // Whole-run limit
  initial begin
    #2ms;
    $display("ERRORS FOUND");
    $fatal(1, "simulation did not finish in time");
  end

endmodule
